// File: logic/soc_map_pkg.sv
/* SoC address map: decoded regions and the default
   base and length of each region window */
package soc_map_pkg;

   // --------------------
   // Decoded regions
   // --------------------
   typedef enum logic [2:0] {
      REGION_ROM   = 3'd0,
      REGION_APB   = 3'd1,
      REGION_CLINT = 3'd2,
      REGION_DRAM  = 3'd3,
      REGION_NONE  = 3'd4
   } soc_region_e;

   // --------------------
   // Default windows
   // --------------------
   // Boot ROM
   localparam logic [63:0] ROM_BASE     = 64'h0000_0000_0001_0000;
   localparam logic [63:0] ROM_LENGTH   = 64'h0000_0000_0001_0000;

   // Peripheral bus behind the APB bridge
   localparam logic [63:0] APB_BASE     = 64'h0000_0000_6000_0000;
   localparam logic [63:0] APB_LENGTH   = 64'h0000_0000_1000_0000;

   // Core-local interruptor
   localparam logic [63:0] CLINT_BASE   = 64'h0000_0000_0200_0000;
   localparam logic [63:0] CLINT_LENGTH = 64'h0000_0000_000C_0000;

   // Main memory
   localparam logic [63:0] DRAM_BASE    = 64'h0000_0000_8000_0000;
   localparam logic [63:0] DRAM_LENGTH  = 64'h0000_0000_2000_0000;

endpackage

// File: logic/bus_pkg.sv
/* Master bus definitions: widths, opcodes and
   response codes */
package bus_pkg;

   // --------------------
   // Widths
   // --------------------
   localparam int ADDR_WIDTH = 64;
   localparam int DATA_WIDTH = 64;
   // APB side is narrower
   localparam int APB_WIDTH  = 32;

   // --------------------
   // Opcodes
   // --------------------
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } bus_op_e;

   // --------------------
   // Responses
   // --------------------
   // Same encoding as AXI xRESP, EXOKAY unused
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } bus_resp_e;

endpackage

// File: logic/addr_decoder.sv
/* Address decoder: matches an address against the
   region windows and reports the hit region */
`timescale 1ns/1ps

module addr_decoder #(
   parameter logic [63:0] ROM_BASE     = soc_map_pkg::ROM_BASE,
   parameter logic [63:0] ROM_LENGTH   = soc_map_pkg::ROM_LENGTH,
   parameter logic [63:0] APB_BASE     = soc_map_pkg::APB_BASE,
   parameter logic [63:0] APB_LENGTH   = soc_map_pkg::APB_LENGTH,
   parameter logic [63:0] CLINT_BASE   = soc_map_pkg::CLINT_BASE,
   parameter logic [63:0] CLINT_LENGTH = soc_map_pkg::CLINT_LENGTH,
   parameter logic [63:0] DRAM_BASE    = soc_map_pkg::DRAM_BASE,
   parameter logic [63:0] DRAM_LENGTH  = soc_map_pkg::DRAM_LENGTH
) (
   input  logic [bus_pkg::ADDR_WIDTH-1:0] dec_addr_i,
   output soc_map_pkg::soc_region_e       dec_region_o
);

   // Base inclusive, end exclusive
   function automatic logic in_window(
      input logic [bus_pkg::ADDR_WIDTH-1:0] addr,
      input logic [63:0]                    base,
      input logic [63:0]                    length
   );
      logic [bus_pkg::ADDR_WIDTH-1:0] lo;
      logic [bus_pkg::ADDR_WIDTH-1:0] hi;
      lo = base[bus_pkg::ADDR_WIDTH-1:0];
      hi = base[bus_pkg::ADDR_WIDTH-1:0] + length[bus_pkg::ADDR_WIDTH-1:0];
      return (addr >= lo) && (addr < hi);
   endfunction

   // First match wins
   always_comb begin
      if (in_window(dec_addr_i, ROM_BASE, ROM_LENGTH)) begin
         dec_region_o = soc_map_pkg::REGION_ROM;
      end else if (in_window(dec_addr_i, APB_BASE, APB_LENGTH)) begin
         dec_region_o = soc_map_pkg::REGION_APB;
      end else if (in_window(dec_addr_i, CLINT_BASE, CLINT_LENGTH)) begin
         dec_region_o = soc_map_pkg::REGION_CLINT;
      end else if (in_window(dec_addr_i, DRAM_BASE, DRAM_LENGTH)) begin
         dec_region_o = soc_map_pkg::REGION_DRAM;
      end else begin
         dec_region_o = soc_map_pkg::REGION_NONE;
      end
   end

endmodule

// File: logic/apb_bridge.sv
/* 64-to-32-bit APB bridge: runs one setup and access
   transfer per start pulse */
`timescale 1ns/1ps

module apb_bridge (
   input  logic                           clk,
   input  logic                           arst_n_i,
   // Request from the router
   input  logic                           apb_start_i,
   input  logic                           apb_write_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0] apb_addr_i,
   input  logic [bus_pkg::DATA_WIDTH-1:0] apb_wdata_i,
   output logic                           apb_done_o,
   output logic [bus_pkg::DATA_WIDTH-1:0] apb_rdata_o,
   output logic                           apb_err_o,
   // APB pins
   output logic                           psel_o,
   output logic                           penable_o,
   output logic                           pwrite_o,
   output logic [bus_pkg::APB_WIDTH-1:0]  paddr_o,
   output logic [bus_pkg::APB_WIDTH-1:0]  pwdata_o,
   input  logic [bus_pkg::APB_WIDTH-1:0]  prdata_i,
   input  logic                           pready_i,
   input  logic                           pslverr_i
);

   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } apb_state_e;

   apb_state_e state_q;
   apb_state_e state_d;
   logic       launch;
   logic       xfer_end;

   assign launch   = (state_q == IDLE) && apb_start_i;
   assign xfer_end = (state_q == ACCESS) && pready_i;

   // --------------------
   // Transfer FSM
   // --------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (apb_start_i) begin
               state_d = SETUP;
            end
         end
         SETUP:   state_d = ACCESS;
         // Slave may stretch the access phase
         ACCESS: begin
            if (pready_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= IDLE;
         apb_done_o <= 1'b0;
      end else begin
         state_q    <= state_d;
         apb_done_o <= xfer_end;
      end
   end

   // --------------------
   // Payload
   // --------------------
   always_ff @(posedge clk) begin
      if (launch) begin
         pwrite_o <= apb_write_i;
         paddr_o  <= apb_addr_i[bus_pkg::APB_WIDTH-1:0];
         pwdata_o <= apb_wdata_i[bus_pkg::APB_WIDTH-1:0];
      end
      if (xfer_end) begin
         apb_rdata_o <= {{(bus_pkg::DATA_WIDTH - bus_pkg::APB_WIDTH){1'b0}}, prdata_i};
         apb_err_o   <= pslverr_i;
      end
   end

   assign psel_o    = (state_q != IDLE);
   assign penable_o = (state_q == ACCESS);

endmodule

// File: logic/periph_router.sv
/* Request router: holds one master request, sends it to the
   memory port, the APB bridge or a decode error, and answers */
`timescale 1ns/1ps

module periph_router (
   input  logic                           clk,
   input  logic                           arst_n_i,
   // Master request and response
   input  logic                           req_valid_i,
   input  bus_pkg::bus_op_e               req_op_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0] req_addr_i,
   input  logic [bus_pkg::DATA_WIDTH-1:0] req_wdata_i,
   output logic                           req_ready_o,
   output logic                           rsp_valid_o,
   output bus_pkg::bus_resp_e             rsp_status_o,
   output logic [bus_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
   // Shared memory target port
   output logic                           mem_req_o,
   output soc_map_pkg::soc_region_e       mem_target_o,
   output logic                           mem_we_o,
   output logic [bus_pkg::ADDR_WIDTH-1:0] mem_addr_o,
   output logic [bus_pkg::DATA_WIDTH-1:0] mem_wdata_o,
   input  logic [bus_pkg::DATA_WIDTH-1:0] mem_rdata_i,
   input  logic                           mem_ack_i,
   input  logic                           mem_err_i,
   // Decoder
   output logic [bus_pkg::ADDR_WIDTH-1:0] dec_addr_o,
   input  soc_map_pkg::soc_region_e       dec_region_i,
   // APB bridge
   output logic                           apb_start_o,
   output logic                           apb_write_o,
   output logic [bus_pkg::ADDR_WIDTH-1:0] apb_addr_o,
   output logic [bus_pkg::DATA_WIDTH-1:0] apb_wdata_o,
   input  logic                           apb_done_i,
   input  logic [bus_pkg::DATA_WIDTH-1:0] apb_rdata_i,
   input  logic                           apb_err_i
);

   typedef enum logic [2:0] {
      IDLE,
      DECODE,
      MEM_WAIT,
      APB_WAIT,
      RESPOND
   } router_state_e;

   router_state_e                  state_q;
   router_state_e                  state_d;
   bus_pkg::bus_op_e               op_q;
   logic [bus_pkg::ADDR_WIDTH-1:0] addr_q;
   logic [bus_pkg::DATA_WIDTH-1:0] wdata_q;
   bus_pkg::bus_resp_e             status_q;
   logic [bus_pkg::DATA_WIDTH-1:0] rdata_q;
   logic                           is_read;
   logic                           mem_hit;
   logic                           mem_done;
   logic                           dec_miss;

   assign is_read  = (op_q == bus_pkg::OP_READ);
   assign mem_hit  = (dec_region_i == soc_map_pkg::REGION_ROM)
                  || (dec_region_i == soc_map_pkg::REGION_CLINT)
                  || (dec_region_i == soc_map_pkg::REGION_DRAM);
   assign dec_miss = (state_q == DECODE) && (dec_region_i == soc_map_pkg::REGION_NONE);

   // --------------------
   // Control FSM
   // --------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (req_valid_i) begin
               state_d = DECODE;
            end
         end
         DECODE: begin
            if (mem_hit) begin
               state_d = mem_ack_i ? RESPOND : MEM_WAIT;
            end else if (dec_region_i == soc_map_pkg::REGION_APB) begin
               state_d = APB_WAIT;
            end else begin
               state_d = RESPOND;
            end
         end
         MEM_WAIT: begin
            if (mem_ack_i) begin
               state_d = RESPOND;
            end
         end
         // Bridge answers straight to the master
         APB_WAIT: begin
            if (apb_done_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Captured request and pending response
   always_ff @(posedge clk) begin
      if (req_valid_i && req_ready_o) begin
         op_q    <= req_op_i;
         addr_q  <= req_addr_i;
         wdata_q <= req_wdata_i;
      end
      if (dec_miss) begin
         status_q <= bus_pkg::RESP_DECERR;
         rdata_q  <= '0;
      end else if (mem_done) begin
         status_q <= mem_err_i ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
         rdata_q  <= is_read ? mem_rdata_i : '0;
      end
   end

   assign req_ready_o = (state_q == IDLE);
   assign dec_addr_o  = addr_q;

   // --------------------
   // Target side
   // --------------------
   assign mem_req_o    = ((state_q == DECODE) && mem_hit) || (state_q == MEM_WAIT);
   assign mem_done     = mem_req_o && mem_ack_i;
   assign mem_target_o = dec_region_i;
   assign mem_we_o     = (op_q == bus_pkg::OP_WRITE);
   assign mem_addr_o   = addr_q;
   assign mem_wdata_o  = wdata_q;

   assign apb_start_o = (state_q == DECODE) && (dec_region_i == soc_map_pkg::REGION_APB);
   assign apb_write_o = (op_q == bus_pkg::OP_WRITE);
   assign apb_addr_o  = addr_q;
   assign apb_wdata_o = wdata_q;

   // --------------------
   // Response
   // --------------------
   always_comb begin
      if (state_q == APB_WAIT) begin
         rsp_valid_o  = apb_done_i;
         rsp_status_o = apb_err_i ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
         rsp_rdata_o  = is_read ? apb_rdata_i : '0;
      end else begin
         rsp_valid_o  = (state_q == RESPOND);
         rsp_status_o = status_q;
         rsp_rdata_o  = rdata_q;
      end
   end

endmodule

// File: logic/soc_interconnect_top.sv
/* Peripheral interconnect top: router, address decoder
   and APB bridge for one bus master */
`timescale 1ns/1ps

module soc_interconnect_top #(
   parameter logic [63:0] ROM_BASE     = soc_map_pkg::ROM_BASE,
   parameter logic [63:0] ROM_LENGTH   = soc_map_pkg::ROM_LENGTH,
   parameter logic [63:0] APB_BASE     = soc_map_pkg::APB_BASE,
   parameter logic [63:0] APB_LENGTH   = soc_map_pkg::APB_LENGTH,
   parameter logic [63:0] CLINT_BASE   = soc_map_pkg::CLINT_BASE,
   parameter logic [63:0] CLINT_LENGTH = soc_map_pkg::CLINT_LENGTH,
   parameter logic [63:0] DRAM_BASE    = soc_map_pkg::DRAM_BASE,
   parameter logic [63:0] DRAM_LENGTH  = soc_map_pkg::DRAM_LENGTH
) (
   input  logic                           clk,
   input  logic                           arst_n_i,
   // Master
   input  logic                           req_valid_i,
   input  bus_pkg::bus_op_e               req_op_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0] req_addr_i,
   input  logic [bus_pkg::DATA_WIDTH-1:0] req_wdata_i,
   output logic                           req_ready_o,
   output logic                           rsp_valid_o,
   output bus_pkg::bus_resp_e             rsp_status_o,
   output logic [bus_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
   // ROM, CLINT and DRAM
   output logic                           mem_req_o,
   output soc_map_pkg::soc_region_e       mem_target_o,
   output logic                           mem_we_o,
   output logic [bus_pkg::ADDR_WIDTH-1:0] mem_addr_o,
   output logic [bus_pkg::DATA_WIDTH-1:0] mem_wdata_o,
   input  logic [bus_pkg::DATA_WIDTH-1:0] mem_rdata_i,
   input  logic                           mem_ack_i,
   input  logic                           mem_err_i,
   // APB
   output logic                           psel_o,
   output logic                           penable_o,
   output logic                           pwrite_o,
   output logic [bus_pkg::APB_WIDTH-1:0]  paddr_o,
   output logic [bus_pkg::APB_WIDTH-1:0]  pwdata_o,
   input  logic [bus_pkg::APB_WIDTH-1:0]  prdata_i,
   input  logic                           pready_i,
   input  logic                           pslverr_i
);

   logic [bus_pkg::ADDR_WIDTH-1:0] dec_addr;
   soc_map_pkg::soc_region_e       dec_region;
   logic                           apb_start;
   logic                           apb_write;
   logic [bus_pkg::ADDR_WIDTH-1:0] apb_addr;
   logic [bus_pkg::DATA_WIDTH-1:0] apb_wdata;
   logic                           apb_done;
   logic [bus_pkg::DATA_WIDTH-1:0] apb_rdata;
   logic                           apb_err;

   // --------------------
   // Router
   // --------------------
   periph_router i_periph_router (
      .clk          ( clk          ),
      .arst_n_i     ( arst_n_i     ),
      .req_valid_i  ( req_valid_i  ),
      .req_op_i     ( req_op_i     ),
      .req_addr_i   ( req_addr_i   ),
      .req_wdata_i  ( req_wdata_i  ),
      .req_ready_o  ( req_ready_o  ),
      .rsp_valid_o  ( rsp_valid_o  ),
      .rsp_status_o ( rsp_status_o ),
      .rsp_rdata_o  ( rsp_rdata_o  ),
      .mem_req_o    ( mem_req_o    ),
      .mem_target_o ( mem_target_o ),
      .mem_we_o     ( mem_we_o     ),
      .mem_addr_o   ( mem_addr_o   ),
      .mem_wdata_o  ( mem_wdata_o  ),
      .mem_rdata_i  ( mem_rdata_i  ),
      .mem_ack_i    ( mem_ack_i    ),
      .mem_err_i    ( mem_err_i    ),
      .dec_addr_o   ( dec_addr     ),
      .dec_region_i ( dec_region   ),
      .apb_start_o  ( apb_start    ),
      .apb_write_o  ( apb_write    ),
      .apb_addr_o   ( apb_addr     ),
      .apb_wdata_o  ( apb_wdata    ),
      .apb_done_i   ( apb_done     ),
      .apb_rdata_i  ( apb_rdata    ),
      .apb_err_i    ( apb_err      )
   );

   // Region windows come from the top parameters
   addr_decoder #(
      .ROM_BASE     ( ROM_BASE     ),
      .ROM_LENGTH   ( ROM_LENGTH   ),
      .APB_BASE     ( APB_BASE     ),
      .APB_LENGTH   ( APB_LENGTH   ),
      .CLINT_BASE   ( CLINT_BASE   ),
      .CLINT_LENGTH ( CLINT_LENGTH ),
      .DRAM_BASE    ( DRAM_BASE    ),
      .DRAM_LENGTH  ( DRAM_LENGTH  )
   ) i_addr_decoder (
      .dec_addr_i   ( dec_addr     ),
      .dec_region_o ( dec_region   )
   );

   // --------------------
   // APB
   // --------------------
   apb_bridge i_apb_bridge (
      .clk         ( clk       ),
      .arst_n_i    ( arst_n_i  ),
      .apb_start_i ( apb_start ),
      .apb_write_i ( apb_write ),
      .apb_addr_i  ( apb_addr  ),
      .apb_wdata_i ( apb_wdata ),
      .apb_done_o  ( apb_done  ),
      .apb_rdata_o ( apb_rdata ),
      .apb_err_o   ( apb_err   ),
      .psel_o      ( psel_o    ),
      .penable_o   ( penable_o ),
      .pwrite_o    ( pwrite_o  ),
      .paddr_o     ( paddr_o   ),
      .pwdata_o    ( pwdata_o  ),
      .prdata_i    ( prdata_i  ),
      .pready_i    ( pready_i  ),
      .pslverr_i   ( pslverr_i )
   );

endmodule

// File: testbench/tb_clk_gen.sv
/* Testbench clock and reset source */
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release away from both clock edges
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      #(PERIOD_NS / 4);
      arst_n_o = 1'b1;
   end

endmodule

// File: testbench/soc_interconnect_chk.sv
/* Protocol assertions on the interconnect top */
`timescale 1ns/1ps

module soc_interconnect_chk (
   input logic clk_i,
   input logic arst_n_i,
   input logic req_ready_i,
   input logic rsp_valid_i,
   input logic mem_req_i,
   input logic psel_i,
   input logic penable_i
);

   // Count of failed assertions
   int unsigned fail_count = 0;

   penable_needs_psel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      penable_i |-> psel_i)
   else begin
      $error("penable_o high without psel_o");
      fail_count++;
   end

   one_target_at_a_time: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(mem_req_i && psel_i))
   else begin
      $error("mem_req_o and psel_o high together");
      fail_count++;
   end

   rsp_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_i |=> !rsp_valid_i)
   else begin
      $error("rsp_valid_o longer than one cycle");
      fail_count++;
   end

   // No new request while a target works
   ready_low_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (mem_req_i || psel_i) |-> !req_ready_i)
   else begin
      $error("req_ready_o high while busy");
      fail_count++;
   end

endmodule

bind soc_interconnect_top soc_interconnect_chk i_soc_interconnect_chk (
   .clk_i       ( clk         ),
   .arst_n_i    ( arst_n_i    ),
   .req_ready_i ( req_ready_o ),
   .rsp_valid_i ( rsp_valid_o ),
   .mem_req_i   ( mem_req_o   ),
   .psel_i      ( psel_o      ),
   .penable_i   ( penable_o   )
);

// File: testbench/tb_soc_interconnect.sv
/* Testbench for the peripheral interconnect: table of requests
   applied against memory and APB target models */
`timescale 1ns/1ps

module tb_soc_interconnect;

   localparam int          CLK_PERIOD = 100;
   localparam int          TIMEOUT    = 40;
   localparam int          MAX_ROWS   = 16;
   localparam logic [63:0] MEM_MASK   = 64'hA5A5_0000_5A5A_0000;

   logic                           clk;
   logic                           arst_n_i;
   logic                           req_valid_i;
   bus_pkg::bus_op_e               req_op_i;
   logic [bus_pkg::ADDR_WIDTH-1:0] req_addr_i;
   logic [bus_pkg::DATA_WIDTH-1:0] req_wdata_i;
   logic                           req_ready_o;
   logic                           rsp_valid_o;
   bus_pkg::bus_resp_e             rsp_status_o;
   logic [bus_pkg::DATA_WIDTH-1:0] rsp_rdata_o;
   logic                           mem_req_o;
   soc_map_pkg::soc_region_e       mem_target_o;
   logic                           mem_we_o;
   logic [bus_pkg::ADDR_WIDTH-1:0] mem_addr_o;
   logic [bus_pkg::DATA_WIDTH-1:0] mem_wdata_o;
   logic [bus_pkg::DATA_WIDTH-1:0] mem_rdata_i;
   logic                           mem_ack_i;
   logic                           mem_err_i;
   logic                           psel_o;
   logic                           penable_o;
   logic                           pwrite_o;
   logic [bus_pkg::APB_WIDTH-1:0]  paddr_o;
   logic [bus_pkg::APB_WIDTH-1:0]  pwdata_o;
   logic [bus_pkg::APB_WIDTH-1:0]  prdata_i;
   logic                           pready_i;
   logic                           pslverr_i;

   // Stimulus table, one entry per request
   string                          t_name   [MAX_ROWS];
   bus_pkg::bus_op_e               t_op     [MAX_ROWS];
   logic [63:0]                    t_addr   [MAX_ROWS];
   logic [63:0]                    t_wdata  [MAX_ROWS];
   soc_map_pkg::soc_region_e       t_region [MAX_ROWS];
   bus_pkg::bus_resp_e             t_status [MAX_ROWS];
   logic [63:0]                    t_rdata  [MAX_ROWS];
   logic                           t_hold   [MAX_ROWS];
   int                             num_rows = 0;

   // Target model state
   logic [15:0] lfsr_q      = 16'd54;
   logic        mem_busy    = 1'b0;
   logic        apb_busy    = 1'b0;
   int          mem_left    = 0;
   int          apb_left    = 0;
   time         answer_time = 0;

   tb_clk_gen #(
      .PERIOD_NS    ( CLK_PERIOD ),
      .RESET_CYCLES ( 10         )
   ) i_tb_clk_gen (
      .clk_o    ( clk      ),
      .arst_n_o ( arst_n_i )
   );

   soc_interconnect_top i_soc_interconnect_top (.*);

   // --------------------
   // Random delays
   // --------------------
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // 0 to 3 cycles, two LFSR bits
   task automatic draw_delay(output int d);
      d = 0;
      repeat (2) begin
         d = (d << 1) | lfsr_q[0];
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   // --------------------
   // Target models
   // --------------------
   always @(negedge clk) begin
      if (mem_ack_i) begin
         mem_ack_i = 1'b0;
         mem_err_i = 1'b0;
      end else if (mem_req_o && arst_n_i) begin
         if (!mem_busy) begin
            mem_busy = 1'b1;
            draw_delay(mem_left);
         end
         if (mem_left == 0) begin
            mem_ack_i   = 1'b1;
            mem_rdata_i = mem_addr_o ^ MEM_MASK;
            mem_err_i   = (mem_target_o == soc_map_pkg::REGION_DRAM) && mem_addr_o[12];
            mem_busy    = 1'b0;
            answer_time = $time;
         end else begin
            mem_left--;
         end
      end
   end

   // Answers in the access phase
   always @(negedge clk) begin
      if (pready_i) begin
         pready_i  = 1'b0;
         pslverr_i = 1'b0;
      end else if (psel_o && penable_o && arst_n_i) begin
         if (!apb_busy) begin
            apb_busy = 1'b1;
            draw_delay(apb_left);
         end
         if (apb_left == 0) begin
            pready_i    = 1'b1;
            prdata_i    = ~paddr_o;
            pslverr_i   = paddr_o[8];
            apb_busy    = 1'b0;
            answer_time = $time;
         end else begin
            apb_left--;
         end
      end
   end

   // --------------------
   // Compare tasks
   // --------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_status(input string name, input bus_pkg::bus_resp_e exp,
                               input bus_pkg::bus_resp_e act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name()));
      end
   endtask

   task automatic check_data(input string name, input logic [bus_pkg::DATA_WIDTH-1:0] exp,
                             input logic [bus_pkg::DATA_WIDTH-1:0] act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_region(input string name, input soc_map_pkg::soc_region_e exp,
                               input soc_map_pkg::soc_region_e act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name()));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // Protocol assertions in the bound checker
   always @(i_soc_interconnect_top.i_soc_interconnect_chk.fail_count) begin
      if (i_soc_interconnect_top.i_soc_interconnect_chk.fail_count != 0) begin
         abort_run("a protocol assertion on the DUT failed");
      end
   end

   // --------------------
   // Table
   // --------------------
   // Read data follows the target model rules
   task automatic add_row(input string name, input bus_pkg::bus_op_e op, input logic [63:0] addr,
                          input logic [63:0] wdata, input soc_map_pkg::soc_region_e region,
                          input bus_pkg::bus_resp_e status, input logic hold);
      t_name[num_rows]   = name;
      t_op[num_rows]     = op;
      t_addr[num_rows]   = addr;
      t_wdata[num_rows]  = wdata;
      t_region[num_rows] = region;
      t_status[num_rows] = status;
      t_hold[num_rows]   = hold;
      t_rdata[num_rows]  = '0;
      if (op == bus_pkg::OP_READ && region == soc_map_pkg::REGION_APB) begin
         t_rdata[num_rows] = {32'h0, ~addr[31:0]};
      end else if (op == bus_pkg::OP_READ && region != soc_map_pkg::REGION_NONE) begin
         t_rdata[num_rows] = addr ^ MEM_MASK;
      end
      num_rows++;
   endtask

   task automatic fill_table();
      add_row("rom_read", bus_pkg::OP_READ, soc_map_pkg::ROM_BASE + 64'h40, 64'h0,
              soc_map_pkg::REGION_ROM, bus_pkg::RESP_OKAY, 1'b0);
      add_row("clint_read", bus_pkg::OP_READ, soc_map_pkg::CLINT_BASE + 64'h4000, 64'h0,
              soc_map_pkg::REGION_CLINT, bus_pkg::RESP_OKAY, 1'b0);
      add_row("dram_read", bus_pkg::OP_READ, soc_map_pkg::DRAM_BASE + 64'h100, 64'h0,
              soc_map_pkg::REGION_DRAM, bus_pkg::RESP_OKAY, 1'b0);
      add_row("dram_write", bus_pkg::OP_WRITE, soc_map_pkg::DRAM_BASE + 64'h2008,
              64'h0123_4567_89AB_CDEF, soc_map_pkg::REGION_DRAM, bus_pkg::RESP_OKAY, 1'b0);
      add_row("apb_read", bus_pkg::OP_READ, soc_map_pkg::APB_BASE + 64'h24, 64'h0,
              soc_map_pkg::REGION_APB, bus_pkg::RESP_OKAY, 1'b0);
      add_row("apb_write", bus_pkg::OP_WRITE, soc_map_pkg::APB_BASE + 64'h30,
              64'hDEAD_BEEF_1234_5678, soc_map_pkg::REGION_APB, bus_pkg::RESP_OKAY, 1'b0);
      add_row("unmapped_read", bus_pkg::OP_READ, 64'h0000_0000_3000_0000, 64'h0,
              soc_map_pkg::REGION_NONE, bus_pkg::RESP_DECERR, 1'b0);
      add_row("dram_err_read", bus_pkg::OP_READ, soc_map_pkg::DRAM_BASE + 64'h1010, 64'h0,
              soc_map_pkg::REGION_DRAM, bus_pkg::RESP_SLVERR, 1'b0);
      add_row("apb_err_write", bus_pkg::OP_WRITE, soc_map_pkg::APB_BASE + 64'h104,
              64'h0000_0000_CAFE_F00D, soc_map_pkg::REGION_APB, bus_pkg::RESP_SLVERR, 1'b0);
      // Next row is held on req_valid_i meanwhile
      add_row("dram_read_held", bus_pkg::OP_READ, soc_map_pkg::DRAM_BASE + 64'h2200, 64'h0,
              soc_map_pkg::REGION_DRAM, bus_pkg::RESP_OKAY, 1'b1);
      add_row("apb_read_waiting", bus_pkg::OP_READ, soc_map_pkg::APB_BASE + 64'h2040, 64'h0,
              soc_map_pkg::REGION_APB, bus_pkg::RESP_OKAY, 1'b0);
   endtask

   // --------------------
   // Request sequencing
   // --------------------
   task automatic drive_request(input int idx);
      req_valid_i = 1'b1;
      req_op_i    = t_op[idx];
      req_addr_i  = t_addr[idx];
      req_wdata_i = t_wdata[idx];
   endtask

   // Returns in the first cycle after acceptance
   task automatic issue_request(input int idx);
      int waited;
      waited = 0;
      drive_request(idx);
      while (!req_ready_o) begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            abort_run($sformatf("%s: timeout waiting for req_ready_o", t_name[idx]));
         end
      end
      @(negedge clk);
      req_valid_i = 1'b0;
      if (t_hold[idx] && idx + 1 < num_rows) begin
         drive_request(idx + 1);
      end
   endtask

   task automatic step_cycle(input int idx, input string what, inout int cycles, inout int waited);
      check_bit({t_name[idx], " req_ready_o"}, 1'b0, req_ready_o);
      @(negedge clk);
      cycles++;
      waited++;
      if (waited > TIMEOUT) begin
         abort_run($sformatf("%s: timeout waiting for %s", t_name[idx], what));
      end
   endtask

   task automatic watch_targets(input int idx, input int cycles, inout int mem_first,
                                inout int apb_first, inout soc_map_pkg::soc_region_e seen);
      logic is_write;
      is_write = (t_op[idx] == bus_pkg::OP_WRITE);
      if (mem_req_o) begin
         if (mem_first < 0) begin
            mem_first = cycles;
            seen      = mem_target_o;
         end
         check_data({t_name[idx], " mem_addr_o"}, t_addr[idx], mem_addr_o);
         check_bit({t_name[idx], " mem_we_o"}, is_write, mem_we_o);
         if (is_write) begin
            check_data({t_name[idx], " mem_wdata_o"}, t_wdata[idx], mem_wdata_o);
         end
      end
      if (psel_o) begin
         if (apb_first < 0) begin
            apb_first = cycles;
            seen      = soc_map_pkg::REGION_APB;
            check_bit({t_name[idx], " penable_o in setup"}, 1'b0, penable_o);
         end
         check_data({t_name[idx], " paddr_o"}, {32'h0, t_addr[idx][31:0]}, {32'h0, paddr_o});
         check_bit({t_name[idx], " pwrite_o"}, is_write, pwrite_o);
         if (is_write) begin
            check_data({t_name[idx], " pwdata_o"}, {32'h0, t_wdata[idx][31:0]}, {32'h0, pwdata_o});
         end
      end
   endtask

   task automatic run_row(input int idx);
      int                       cycles;
      int                       waited;
      int                       mem_first;
      int                       apb_first;
      soc_map_pkg::soc_region_e seen;
      cycles    = 1;
      mem_first = -1;
      apb_first = -1;
      seen      = soc_map_pkg::REGION_NONE;
      issue_request(idx);
      waited = 0;
      if (t_region[idx] != soc_map_pkg::REGION_NONE) begin
         while (!mem_req_o && !psel_o) begin
            step_cycle(idx, "mem_req_o or psel_o", cycles, waited);
         end
      end
      waited = 0;
      while (!rsp_valid_o) begin
         watch_targets(idx, cycles, mem_first, apb_first, seen);
         step_cycle(idx, "rsp_valid_o", cycles, waited);
      end
      watch_targets(idx, cycles, mem_first, apb_first, seen);
      check_bit({t_name[idx], " req_ready_o"}, 1'b0, req_ready_o);
      check_region({t_name[idx], " region"}, t_region[idx], seen);
      check_status({t_name[idx], " status"}, t_status[idx], rsp_status_o);
      check_data({t_name[idx], " rdata"}, t_rdata[idx], rsp_rdata_o);
      if (mem_first >= 0 && mem_first != 1) begin
         abort_run($sformatf("%s: mem_req_o rose %0d cycles after acceptance", t_name[idx],
                             mem_first));
      end
      if (apb_first >= 0 && apb_first != 2) begin
         abort_run($sformatf("%s: APB setup came %0d cycles after acceptance", t_name[idx],
                             apb_first));
      end
      if (seen != soc_map_pkg::REGION_NONE && $time - answer_time != CLK_PERIOD) begin
         abort_run($sformatf("%s: response not one cycle after the target answer", t_name[idx]));
      end
      if (seen == soc_map_pkg::REGION_NONE && cycles != 2) begin
         abort_run($sformatf("%s: decode error came %0d cycles after acceptance", t_name[idx],
                             cycles));
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      int idx;
      int waited;
      req_valid_i = 1'b0;
      req_op_i    = bus_pkg::OP_READ;
      req_addr_i  = '0;
      req_wdata_i = '0;
      mem_rdata_i = '0;
      mem_ack_i   = 1'b0;
      mem_err_i   = 1'b0;
      prdata_i    = '0;
      pready_i    = 1'b0;
      pslverr_i   = 1'b0;
      fill_table();

      waited = 0;
      while (arst_n_i !== 1'b1) begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("reset was never released");
         end
      end
      @(negedge clk);
      check_bit("reset req_ready_o", 1'b1, req_ready_o);
      check_bit("reset rsp_valid_o", 1'b0, rsp_valid_o);
      check_bit("reset mem_req_o", 1'b0, mem_req_o);
      check_bit("reset psel_o", 1'b0, psel_o);
      check_bit("reset penable_o", 1'b0, penable_o);

      for (idx = 0; idx < num_rows; idx++) begin
         run_row(idx);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: sources.f
logic/soc_map_pkg.sv
logic/bus_pkg.sv
logic/addr_decoder.sv
logic/apb_bridge.sv
logic/periph_router.sv
logic/soc_interconnect_top.sv
testbench/tb_clk_gen.sv
testbench/soc_interconnect_chk.sv
testbench/tb_soc_interconnect.sv

// File: Bender.yml
package:
  name: soc_interconnect

sources:
  - files:
      - logic/soc_map_pkg.sv
      - logic/bus_pkg.sv
      - logic/addr_decoder.sv
      - logic/apb_bridge.sv
      - logic/periph_router.sv
      - logic/soc_interconnect_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/soc_interconnect_chk.sv
      - testbench/tb_soc_interconnect.sv
